/* Makefile */
VERILATOR ?= verilator
TOP       ?= vis_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM) $(SIMFLAGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+design
design/vis_pkg.sv
design/vis_fetch_ctrl.sv
design/vis_prefetch.sv
design/vis_buffer.sv
design/vis_top.sv
tests/vis_chk.sv
tests/vis_tb.sv

/* design/vis_buffer.sv */
`include "vis_macros.svh"

module vis_buffer import vis_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   // word write port from the prefetcher
   input  logic       wr_en_i,
   input  vis_idx_t   wr_idx_i,
   input  vis_word_t  wr_dat_i,
   // byte read port for the host
   input  logic       rd_cyc_i,
   input  logic       rd_stb_i,
   input  vis_badr_t  rd_adr_i,
   output logic       rd_ack_o,
   output logic [7:0] rd_byt_o
);

   localparam int LINE_W = `VIS_LANES * 8; // stored word padded to full lanes

   vis_word_t         mem [0:`VIS_COUNT-1];
   logic              rd_req;
   logic [LINE_W-1:0] line;                // word under the read address

   // ----------------------------------------
   // write side
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_en_i) mem[wr_idx_i] <= wr_dat_i;
   end

   // ----------------------------------------
   // read side
   // ----------------------------------------
   assign rd_req = rd_cyc_i && rd_stb_i;   // host writes are not decoded

   // slots past the bank read as zero, top lane is the zero padding
   always_comb begin
      line = '0;
      if (rd_adr_i.idx < vis_idx_t'(`VIS_COUNT)) begin
         line[`VIS_WORD_W-1:0] = mem[rd_adr_i.idx];
      end
   end

   // ack one cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) rd_ack_o <= 1'b0;
      else rd_ack_o <= rd_req;
   end

   // byte lane select, held between reads
   always_ff @(posedge clk_i) begin
      if (rd_req) rd_byt_o <= line[rd_adr_i.lane*8 +: 8];
   end

endmodule

/* design/vis_fetch_ctrl.sv */
module vis_fetch_ctrl (
   input  logic clk_i,
   input  logic rst_i,
   input  logic switching_i, // correlators swapped banks
   input  logic streamed_i,  // host has read the buffer out
   input  logic done_i,      // prefetcher stored the last word
   output logic start_o,     // one-cycle fetch launch
   output logic available_o  // buffer holds a complete bank
);

   logic ready;  // a bank is waiting to be fetched
   logic empty;  // buffer may be overwritten
   logic busy;   // a fetch is in progress
   logic launch;

   // fetch only into an empty buffer and never on top of a running fetch
   assign launch = ready && empty && !busy;

   // ----------------------------------------
   // ready flag
   // ----------------------------------------
   // a swap during a fetch or a full buffer stays pending here
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ready <= 1'b0;
      end else if (switching_i) begin
         ready <= 1'b1;       // new bank wins over a clear
      end else if (launch) begin
         ready <= 1'b0;       // consumed by the start below
      end
   end

   // ----------------------------------------
   // empty and busy flags
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         empty <= 1'b1;
         busy  <= 1'b0;
      end else begin
         if (streamed_i) empty <= 1'b1;   // host is finished with it
         else if (done_i) empty <= 1'b0;  // fresh bank landed
         if (launch) busy <= 1'b1;
         else if (done_i) busy <= 1'b0;
      end
   end

   // start is a registered copy of the launch condition, one cycle wide
   always_ff @(posedge clk_i) begin
      if (rst_i) start_o <= 1'b0;
      else start_o <= launch;
   end

   assign available_o = !empty;

endmodule

/* design/vis_macros.svh */
`ifndef VIS_MACROS_SVH
`define VIS_MACROS_SVH

// ----------------------------------------
// visibility word and bank geometry
// ----------------------------------------

// width of one correlator visibility word
`define VIS_WORD_W 24

// words fetched from the correlators per bank
`define VIS_COUNT 24

// word index width, enough for VIS_COUNT entries
`define VIS_IDX_W 5

// byte lanes per stored word, top lane is zero padding up to 32 bits
`define VIS_LANES 4

// host byte address: word index on top, lane select below
`define VIS_BADR_W (`VIS_IDX_W + 2)

`endif

/* design/vis_pkg.sv */
`include "vis_macros.svh"

package vis_pkg;

   // ----------------------------------------
   // payload and address types
   // ----------------------------------------

   // one visibility as delivered by a correlator
   typedef logic [`VIS_WORD_W-1:0] vis_word_t;

   // word slot in the local buffer, also the correlator address
   typedef logic [`VIS_IDX_W-1:0] vis_idx_t;

   // host side byte address
   typedef struct packed {
      vis_idx_t                            idx;  // word slot
      logic [`VIS_BADR_W-`VIS_IDX_W-1:0]   lane; // byte within the word
   } vis_badr_t;

   // ----------------------------------------
   // prefetcher sequencing
   // ----------------------------------------

   typedef enum logic [1:0] {
      fs_idle    = 2'd0, // waiting for a start pulse
      fs_request = 2'd1, // walking the correlator addresses
      fs_finish  = 2'd2  // last word stored, signalling done
   } fetch_state_t;

endpackage

/* design/vis_prefetch.sv */
`include "vis_macros.svh"

module vis_prefetch import vis_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,
   // correlator master bus
   output logic      corr_cyc_o,
   output logic      corr_stb_o,
   output vis_idx_t  corr_adr_o,
   input  logic      corr_ack_i,
   input  vis_word_t corr_dat_i,
   // buffer write port
   output logic      wr_en_o,
   output vis_idx_t  wr_idx_o,
   output vis_word_t wr_dat_o,
   // status
   output logic      done_o,
   output vis_word_t checksum_o
);

   localparam vis_idx_t LAST_IDX = vis_idx_t'(`VIS_COUNT - 1);

   fetch_state_t state;
   vis_idx_t     idx;     // current correlator address and buffer slot
   logic         take;    // acked word this cycle

   // only an ack against a live strobe carries data
   assign take = (state == fs_request) && corr_stb_o && corr_ack_i;

   // ----------------------------------------
   // bus sequencing
   // ----------------------------------------
   // one request in flight, stb drops for a cycle after each ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state      <= fs_idle;
         idx        <= '0;
         corr_cyc_o <= 1'b0;
         corr_stb_o <= 1'b0;
         checksum_o <= '0;
      end else begin
         case (state)
            fs_idle: begin
               if (start_i) begin
                  state      <= fs_request;
                  idx        <= '0;       // restart at the first word
                  checksum_o <= '0;       // fresh checksum per bank
                  corr_cyc_o <= 1'b1;
                  corr_stb_o <= 1'b1;
               end
            end
            fs_request: begin
               if (take) begin
                  checksum_o <= checksum_o ^ corr_dat_i;
                  corr_stb_o <= 1'b0;      // gap before next request
                  if (idx == LAST_IDX) begin
                     state      <= fs_finish;
                     corr_cyc_o <= 1'b0;   // release the bus
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end else if (!corr_stb_o) begin
                  corr_stb_o <= 1'b1;      // issue the next address
               end
            end
            fs_finish: begin
               state <= fs_idle;           // done shows for this one cycle
            end
            default: begin
               state      <= fs_idle;
               corr_cyc_o <= 1'b0;
               corr_stb_o <= 1'b0;
            end
         endcase
      end
   end

   assign corr_adr_o = idx;

   // acked data goes straight to the buffer, the write lands on the edge
   assign wr_en_o  = take;
   assign wr_idx_o = idx;
   assign wr_dat_o = corr_dat_i;

   assign done_o = (state == fs_finish);

endmodule

/* design/vis_top.sv */
module vis_top import vis_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   // correlator master bus
   output logic       corr_cyc_o,
   output logic       corr_stb_o,
   output vis_idx_t   corr_adr_o,
   input  logic       corr_ack_i,
   input  vis_word_t  corr_dat_i,
   // host slave bus, byte wide reads
   input  logic       host_cyc_i,
   input  logic       host_stb_i,
   input  vis_badr_t  host_adr_i,
   output logic       host_ack_o,
   output logic [7:0] host_byt_o,
   // bank status
   input  logic       switching_i,
   input  logic       streamed_i,
   output logic       available_o,
   output vis_word_t  checksum_o
);

   // ----------------------------------------
   // internal nets
   // ----------------------------------------
   logic      start;   // controller launches a fetch
   logic      done;    // prefetcher stored the last word
   logic      wr_en;   // buffer write strobe
   vis_idx_t  wr_idx;
   vis_word_t wr_dat;

   // decides when a bank may be fetched
   vis_fetch_ctrl ctrl_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switching_i(switching_i),
      .streamed_i (streamed_i),
      .done_i     (done),
      .start_o    (start),
      .available_o(available_o)
   );

   // pulls the bank over the correlator bus
   vis_prefetch fetch_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .start_i   (start),
      .corr_cyc_o(corr_cyc_o),
      .corr_stb_o(corr_stb_o),
      .corr_adr_o(corr_adr_o),
      .corr_ack_i(corr_ack_i),
      .corr_dat_i(corr_dat_i),
      .wr_en_o   (wr_en),
      .wr_idx_o  (wr_idx),
      .wr_dat_o  (wr_dat),
      .done_o    (done),
      .checksum_o(checksum_o)
   );

   // local copy, read out byte by byte by the host
   vis_buffer buf_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wr_en_i (wr_en),
      .wr_idx_i(wr_idx),
      .wr_dat_i(wr_dat),
      .rd_cyc_i(host_cyc_i),
      .rd_stb_i(host_stb_i),
      .rd_adr_i(host_adr_i),
      .rd_ack_o(host_ack_o),
      .rd_byt_o(host_byt_o)
   );

endmodule

/* tests/vis_chk.sv */
`include "vis_macros.svh"

module vis_chk import vis_pkg::*; (
   input logic     clk_i,
   input logic     rst_i,
   input logic     corr_cyc_i,
   input logic     corr_stb_i,
   input vis_idx_t corr_adr_i,
   input logic     corr_ack_i,
   input logic     host_cyc_i,
   input logic     host_stb_i,
   input logic     host_ack_i,
   input logic     switching_i,
   input logic     available_i
);

   int unsigned fails = 0;   // failed assertions so far
   logic        seen_bank;   // a bank swap happened since reset

   always_ff @(posedge clk_i) begin
      if (rst_i) seen_bank <= 1'b0;
      else if (switching_i) seen_bank <= 1'b1;
   end

   // ----------------------------------------
   // correlator bus
   // ----------------------------------------
   idle_before_bank: assert property (@(posedge clk_i) disable iff (rst_i)
      !seen_bank |-> !corr_cyc_i && !available_i)
      else begin
         $error("correlator bus or available active before any bank swap");
         fails++;
      end

   stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      corr_stb_i |-> corr_cyc_i && (corr_adr_i < vis_idx_t'(`VIS_COUNT)))
      else begin
         $error("correlator strobe outside a cycle or past the bank");
         fails++;
      end

   // request held steady until the ack
   stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      corr_stb_i && !corr_ack_i |=> corr_stb_i && $stable(corr_adr_i))
      else begin
         $error("correlator request dropped or moved before its ack");
         fails++;
      end

   stb_gap: assert property (@(posedge clk_i) disable iff (rst_i)
      corr_stb_i && corr_ack_i |=> !corr_stb_i)
      else begin
         $error("no strobe gap after a correlator ack");
         fails++;
      end

   // ----------------------------------------
   // host bus
   // ----------------------------------------
   host_ack_late: assert property (@(posedge clk_i) disable iff (rst_i)
      host_cyc_i && host_stb_i |=> host_ack_i)
      else begin
         $error("host read not acked one cycle after its strobe");
         fails++;
      end

   host_ack_spur: assert property (@(posedge clk_i) disable iff (rst_i)
      host_ack_i |-> $past(host_cyc_i && host_stb_i))
      else begin
         $error("host ack without a read one cycle before");
         fails++;
      end

endmodule

bind vis_top vis_chk chk_i (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .corr_cyc_i (corr_cyc_o),
   .corr_stb_i (corr_stb_o),
   .corr_adr_i (corr_adr_o),
   .corr_ack_i (corr_ack_i),
   .host_cyc_i (host_cyc_i),
   .host_stb_i (host_stb_i),
   .host_ack_i (host_ack_o),
   .switching_i(switching_i),
   .available_i(available_o)
);

/* tests/vis_tb.sv */
`include "vis_macros.svh"

module vis_tb import vis_pkg::*; ();

   localparam int CLK_HALF     = 20;                          // 40 unit period
   localparam int BYTES        = `VIS_COUNT * `VIS_LANES;     // host addresses per bank
   localparam int WATCHDOG_CYC = 4 * `VIS_COUNT * 6 + 4 * BYTES * 3 + 600;

   logic       clk;
   logic       rst;
   logic       corr_cyc;
   logic       corr_stb;
   vis_idx_t   corr_adr;
   logic       corr_ack;
   vis_word_t  corr_dat;
   logic       host_cyc;
   logic       host_stb;
   vis_badr_t  host_adr;
   logic       host_ack;
   logic [7:0] host_byt;
   logic       switching;
   logic       streamed;
   logic       available;
   vis_word_t  checksum;

   logic [31:0] lfsr;                         // wait state and data noise source
   vis_word_t   exp_words [0:`VIS_COUNT-1];   // words the model handed out
   int          bank;                         // tags the model data
   int          acks;                         // acks given in the current fetch
   int          next_adr;                     // address the model expects next
   int          errors;
   int          lat;

   vis_top dut_i (
      .clk_i      (clk),
      .rst_i      (rst),
      .corr_cyc_o (corr_cyc),
      .corr_stb_o (corr_stb),
      .corr_adr_o (corr_adr),
      .corr_ack_i (corr_ack),
      .corr_dat_i (corr_dat),
      .host_cyc_i (host_cyc),
      .host_stb_i (host_stb),
      .host_adr_i (host_adr),
      .host_ack_o (host_ack),
      .host_byt_o (host_byt),
      .switching_i(switching),
      .streamed_i (streamed),
      .available_o(available),
      .checksum_o (checksum)
   );

   always #CLK_HALF clk = ~clk;

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   // galois lfsr, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
         errors++;
         abort_run();
      end
   endtask

   // pulses start on a falling edge and last one cycle
   task automatic pulse_switching();
      bank++;                      // new bank on the correlator side
      switching = 1'b1;
      @(negedge clk);
      switching = 1'b0;
   endtask

   task automatic pulse_streamed();
      streamed = 1'b1;
      @(negedge clk);
      streamed = 1'b0;
   endtask

   task automatic wait_available();
      while (!available) @(negedge clk);   // watchdog bounds this
   endtask

   // fetch count, checksum and full byte readout against the model record
   task automatic check_bank();
      vis_word_t  sum;
      logic [7:0] exp_byt;
      int         idx;
      int         lane;
      check_value($sformatf("bank %0d ack count", bank), `VIS_COUNT, acks);
      sum = '0;
      for (int i = 0; i < `VIS_COUNT; i++) sum ^= exp_words[i];
      check_value($sformatf("bank %0d checksum", bank), 32'(sum), 32'(checksum));
      for (int a = 0; a < BYTES; a++) begin
         idx     = a / `VIS_LANES;
         lane    = a % `VIS_LANES;
         exp_byt = (lane < `VIS_LANES - 1) ? exp_words[idx][lane*8 +: 8] : 8'h00;
         host_cyc = 1'b1;
         host_stb = 1'b1;                  // single cycle strobe
         host_adr = vis_badr_t'(a[`VIS_BADR_W-1:0]);
         @(negedge clk);
         host_cyc = 1'b0;
         host_stb = 1'b0;
         while (!host_ack) @(negedge clk);
         check_value($sformatf("bank %0d byte %0d", bank, a), 32'(exp_byt), 32'(host_byt));
      end
   endtask

   // ----------------------------------------
   // correlator bus model
   // ----------------------------------------
   initial begin : corr_model
      logic [31:0] wait_n;
      forever begin
         @(negedge clk);
         corr_ack = 1'b0;                  // ack lasts one cycle
         if (!rst && corr_cyc && corr_stb) begin
            check_value("correlator address order", 32'(next_adr), 32'(corr_adr));
            wait_n = take_bits(2);         // 0 to 3 wait states
            repeat (wait_n) @(negedge clk);
            // lfsr state adds the noise
            corr_dat = vis_word_t'(bank * 4096 + int'(corr_adr) * 37 + int'(lfsr));
            corr_ack = 1'b1;
            exp_words[corr_adr] = corr_dat;
            acks++;
            next_adr = (next_adr == `VIS_COUNT - 1) ? 0 : next_adr + 1;
         end
      end
   end

   // a tripped assertion in the bound checker ends the run here
   always @(dut_i.chk_i.fails) begin
      if (dut_i.chk_i.fails != 0) begin
         $display("a protocol assertion in the bound checker failed");
         abort_run();
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("watchdog expired, the tests did not finish in time");
      abort_run();
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin : main_seq
      clk       = 1'b0;
      rst       = 1'b1;
      corr_ack  = 1'b0;
      corr_dat  = '0;
      host_cyc  = 1'b0;
      host_stb  = 1'b0;
      host_adr  = '0;
      switching = 1'b0;
      streamed  = 1'b0;
      lfsr      = 32'hf61250eb;
      bank      = 0;
      acks      = 0;
      next_adr  = 0;
      errors    = 0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      // quiet bus and no data until the first swap
      repeat (20) begin
         @(negedge clk);
         check_value("idle without bank", 32'd0, 32'({corr_cyc, available}));
      end

      // bank 1, plain fetch and readout
      acks = 0;
      pulse_switching();
      wait_available();
      check_bank();
      pulse_streamed();

      // bank 2, left in the buffer
      acks = 0;
      pulse_switching();
      wait_available();
      check_bank();

      // bank 3 arrives while full and must wait for streamed
      acks = 0;
      pulse_switching();
      repeat (10) begin
         @(negedge clk);
         check_value("fetch held while full", 32'd1, 32'({corr_cyc, available}));
      end
      pulse_streamed();
      check_value("available drop after streamed", 32'd0, 32'(available));
      lat = 1;
      while (!corr_cyc) begin
         @(negedge clk);
         lat++;
      end
      check_value("pending fetch latency", 32'd3, 32'(lat));  // start two cycles on
      wait_available();
      check_bank();
      pulse_streamed();

      // bank 4
      acks = 0;
      pulse_switching();
      wait_available();
      check_bank();

      if (errors == 0 && dut_i.chk_i.fails == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         abort_run();
      end
   end

endmodule
